/* Makefile */
SIM       = verilator
FLAGS     = --binary --assert -j 0
TOP       = mastermind_tb
FILELIST  = mastermind_top.f
RUN_FLAGS = +verilator+error+limit+100
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | awk '{ print } /^TEST OK$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

/* common/mastermind_macros.svh */
`ifndef MASTERMIND_MACROS_SVH
`define MASTERMIND_MACROS_SVH

// Game timing in clock cycles
`define SHOW_TICKS  100
`define LETTER_GAP  25

// Game rules
`define CODE_LEN    4
`define WIN_SCORE   2
`define START_LIVES 3

// Counter widths, sized for the constants above
`define TIMER_W     7
`define GAP_W       5
`define CNT_W       3
`define IDX_W       2

// Segment patterns, bit 6 is the middle bar
`define SEG_OFF     7'b0000000
`define SEG_DASH    7'b1000000
`define SEG_A       7'b1110111
`define SEG_B       7'b1111100
`define SEG_C       7'b0111001
`define SEG_E       7'b1111001
`define SEG_F       7'b1110001
`define SEG_H       7'b1110110
`define SEG_L       7'b0111000
`define SEG_U       7'b0111110
`define SEG_P       7'b1110011
`define SEG_0       7'b0111111
`define SEG_1       7'b0000110
`define SEG_2       7'b1011011
`define SEG_3       7'b1001111

`endif

/* common/mastermind_pkg.sv */
package mastermind_pkg;

    // Round sequencing, one round in flight at a time
    typedef enum logic [3:0] {
        START,
        SHOW_SCORE,
        SHOW_CODEMAKER,
        CM_ENTRY,
        SHOW_CODEBREAKER,
        SHOW_LIVES,
        CB_ENTRY,
        EVAL_GUESS,
        SHOW_SECRET,
        SHOW_RESULT,
        CHECK_END
    } game_state_t;

    // 0 is blank, 1 to 7 are A C E F H L U
    typedef logic [2:0] letter_t;

    // Points of one player
    typedef logic [1:0] score_t;

    // Guesses left in the round
    typedef logic [1:0] lives_t;

endpackage

/* game_control/code_regs.sv */
`include "mastermind_macros.svh"

module code_regs (
    input  logic                                    clk,
    input  logic                                    rst,
    input  mastermind_pkg::letter_t                 letter_in,
    input  logic                                    store_secret,
    input  logic                                    store_guess,
    input  logic                                    clear_guess,
    input  mastermind_pkg::game_state_t             state,
    output mastermind_pkg::letter_t [`CODE_LEN-1:0] secret,
    output mastermind_pkg::letter_t [`CODE_LEN-1:0] guess,
    output logic [`CNT_W-1:0]                       entry_count,
    output logic                                    code_full
);

    logic [`IDX_W-1:0] slot;

    assign slot      = entry_count[`IDX_W-1:0];
    assign code_full = (entry_count == `CNT_W'(`CODE_LEN));

    // Shared slot counter for both codes
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            entry_count <= '0;
        end else if (clear_guess || state == mastermind_pkg::SHOW_CODEMAKER) begin
            entry_count <= '0;
        end else if (store_secret || store_guess) begin
            entry_count <= entry_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (store_secret)
            secret[slot] <= letter_in;
    end

    always_ff @(posedge clk) begin
        if (clear_guess)
            guess <= '0;
        else if (store_guess)
            guess[slot] <= letter_in;
    end

endmodule

/* game_control/game_fsm.sv */
`include "mastermind_macros.svh"

module game_fsm (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        enter_a,
    input  logic                        enter_b,
    input  mastermind_pkg::letter_t     letter_in,
    input  logic                        code_full,
    input  logic                        all_correct,
    output mastermind_pkg::game_state_t state,
    output logic                        store_secret,
    output logic                        store_guess,
    output logic                        clear_guess,
    output logic                        cm_is_a,
    output mastermind_pkg::lives_t      lives,
    output mastermind_pkg::score_t      score_a,
    output mastermind_pkg::score_t      score_b,
    output logic [`TIMER_W-1:0]         timer
);

    mastermind_pkg::game_state_t next_state;
    logic                        cm_enter;
    logic                        cb_enter;
    logic                        letter_ok;
    logic                        timed_state;
    logic                        timer_done;
    logic                        win_reached;
    logic                        point_to_a;
    logic                        last_correct;
    logic [`GAP_W-1:0]           gap;

    // Role based enter selection
    assign cm_enter = cm_is_a ? enter_a : enter_b;
    assign cb_enter = cm_is_a ? enter_b : enter_a;

    assign letter_ok    = (letter_in != '0) && (gap == '0) && !code_full;
    assign store_secret = (state == mastermind_pkg::CM_ENTRY) && cm_enter && letter_ok;
    assign store_guess  = (state == mastermind_pkg::CB_ENTRY) && cb_enter && letter_ok;
    assign clear_guess  = (state == mastermind_pkg::SHOW_LIVES);

    assign win_reached = (score_a == mastermind_pkg::score_t'(`WIN_SCORE)) ||
                         (score_b == mastermind_pkg::score_t'(`WIN_SCORE));

    // Codebreaker scores on a correct guess, otherwise the codemaker
    assign point_to_a = last_correct ? !cm_is_a : cm_is_a;

    always_comb begin
        case (state)
            mastermind_pkg::SHOW_SCORE,
            mastermind_pkg::SHOW_CODEMAKER,
            mastermind_pkg::SHOW_CODEBREAKER,
            mastermind_pkg::SHOW_LIVES,
            mastermind_pkg::SHOW_SECRET,
            mastermind_pkg::SHOW_RESULT: timed_state = 1'b1;
            // Hold the last screen a full period after the fourth letter
            mastermind_pkg::CM_ENTRY:    timed_state = code_full;
            default:                     timed_state = 1'b0;
        endcase
    end

    assign timer_done = timed_state && (timer == `TIMER_W'(`SHOW_TICKS));

    always_comb begin
        next_state = state;
        case (state)
            mastermind_pkg::START:
                if (enter_a || enter_b) next_state = mastermind_pkg::SHOW_SCORE;
            mastermind_pkg::SHOW_SCORE:
                if (timer_done) next_state = mastermind_pkg::SHOW_CODEMAKER;
            mastermind_pkg::SHOW_CODEMAKER:
                if (timer_done) next_state = mastermind_pkg::CM_ENTRY;
            mastermind_pkg::CM_ENTRY:
                if (timer_done) next_state = mastermind_pkg::SHOW_CODEBREAKER;
            mastermind_pkg::SHOW_CODEBREAKER:
                if (timer_done) next_state = mastermind_pkg::SHOW_LIVES;
            mastermind_pkg::SHOW_LIVES:
                if (timer_done) next_state = mastermind_pkg::CB_ENTRY;
            mastermind_pkg::CB_ENTRY:
                if (code_full && gap == '0) next_state = mastermind_pkg::EVAL_GUESS;
            mastermind_pkg::EVAL_GUESS: begin
                if (cb_enter) begin
                    if (all_correct || lives == mastermind_pkg::lives_t'(1))
                        next_state = mastermind_pkg::SHOW_SECRET;
                    else
                        next_state = mastermind_pkg::SHOW_LIVES;
                end
            end
            mastermind_pkg::SHOW_SECRET:
                if (timer_done) next_state = mastermind_pkg::SHOW_RESULT;
            mastermind_pkg::SHOW_RESULT:
                if (timer_done) next_state = mastermind_pkg::CHECK_END;
            mastermind_pkg::CHECK_END:
                next_state = win_reached ? mastermind_pkg::START
                                         : mastermind_pkg::SHOW_CODEMAKER;
            default:
                next_state = mastermind_pkg::START;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state        <= mastermind_pkg::START;
            timer        <= '0;
            gap          <= '0;
            cm_is_a      <= 1'b0;
            lives        <= mastermind_pkg::lives_t'(`START_LIVES);
            score_a      <= '0;
            score_b      <= '0;
            last_correct <= 1'b0;
        end else begin
            state <= next_state;
            timer <= (timed_state && !timer_done) ? timer + 1'b1 : '0;

            // Ignore enters for a while after each accepted letter
            if (store_secret || store_guess)
                gap <= `GAP_W'(`LETTER_GAP);
            else if (gap != '0)
                gap <= gap - 1'b1;

            case (state)
                mastermind_pkg::START: begin
                    if (enter_a || enter_b) begin
                        cm_is_a <= enter_a;
                        score_a <= '0;
                        score_b <= '0;
                        lives   <= mastermind_pkg::lives_t'(`START_LIVES);
                    end
                end
                mastermind_pkg::EVAL_GUESS: begin
                    if (cb_enter) begin
                        last_correct <= all_correct;
                        // Last life is kept, the round ends instead
                        if (!all_correct && lives != mastermind_pkg::lives_t'(1))
                            lives <= lives - 1'b1;
                    end
                end
                mastermind_pkg::SHOW_SECRET: begin
                    if (timer_done) begin
                        if (point_to_a)
                            score_a <= score_a + 1'b1;
                        else
                            score_b <= score_b + 1'b1;
                    end
                end
                mastermind_pkg::SHOW_RESULT: begin
                    if (timer_done) begin
                        cm_is_a <= !cm_is_a;
                        lives   <= mastermind_pkg::lives_t'(`START_LIVES);
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* mastermind_top.f */
+incdir+common
common/mastermind_pkg.sv
game_control/game_fsm.sv
game_control/code_regs.sv
source/guess_eval.sv
source/display_decode.sv
source/mastermind_top.sv
tests/mastermind_assertions.sv
tests/mastermind_tb.sv

/* source/display_decode.sv */
`include "mastermind_macros.svh"

module display_decode (
    input  mastermind_pkg::game_state_t             state,
    input  mastermind_pkg::letter_t [`CODE_LEN-1:0] secret,
    input  mastermind_pkg::letter_t [`CODE_LEN-1:0] guess,
    input  logic [`CNT_W-1:0]                       entry_count,
    input  logic                                    cm_is_a,
    input  mastermind_pkg::lives_t                  lives,
    input  mastermind_pkg::score_t                  score_a,
    input  mastermind_pkg::score_t                  score_b,
    input  logic [2*`CODE_LEN-1:0]                  led_pairs,
    input  logic [`TIMER_W-1:0]                     timer,
    output logic [7:0]                              led,
    output logic [6:0]                              ssd3,
    output logic [6:0]                              ssd2,
    output logic [6:0]                              ssd1,
    output logic [6:0]                              ssd0
);

    logic [3:0][6:0]     digits;
    logic [`TIMER_W-1:0] quarter;
    logic                win_reached;

    function automatic logic [6:0] letter_seg(input mastermind_pkg::letter_t l);
        case (l)
            3'd1:    return `SEG_A;
            3'd2:    return `SEG_C;
            3'd3:    return `SEG_E;
            3'd4:    return `SEG_F;
            3'd5:    return `SEG_H;
            3'd6:    return `SEG_L;
            3'd7:    return `SEG_U;
            default: return `SEG_OFF;
        endcase
    endfunction

    function automatic logic [6:0] digit_seg(input logic [1:0] v);
        case (v)
            2'd0:    return `SEG_0;
            2'd1:    return `SEG_1;
            2'd2:    return `SEG_2;
            default: return `SEG_3;
        endcase
    endfunction

    // Leftmost digit shows the first letter
    always_comb begin
        digits = {4{`SEG_OFF}};
        case (state)
            mastermind_pkg::START: begin
                digits[2] = `SEG_A;
                digits[1] = `SEG_DASH;
                digits[0] = `SEG_B;
            end
            mastermind_pkg::SHOW_SCORE, mastermind_pkg::SHOW_RESULT: begin
                digits[2] = digit_seg(score_a);
                digits[1] = `SEG_DASH;
                digits[0] = digit_seg(score_b);
            end
            mastermind_pkg::SHOW_CODEMAKER: begin
                digits[2] = `SEG_P;
                digits[1] = `SEG_DASH;
                digits[0] = cm_is_a ? `SEG_A : `SEG_B;
            end
            mastermind_pkg::SHOW_CODEBREAKER: begin
                digits[2] = `SEG_P;
                digits[1] = `SEG_DASH;
                digits[0] = cm_is_a ? `SEG_B : `SEG_A;
            end
            mastermind_pkg::SHOW_LIVES: begin
                digits[2] = `SEG_L;
                digits[1] = `SEG_DASH;
                digits[0] = digit_seg(lives);
            end
            mastermind_pkg::CM_ENTRY, mastermind_pkg::CB_ENTRY: begin
                for (int i = 0; i < `CODE_LEN; i++) begin
                    // Secret letters stay hidden from the codebreaker
                    if (i >= int'(entry_count))
                        digits[3-i] = `SEG_OFF;
                    else if (state == mastermind_pkg::CM_ENTRY)
                        digits[3-i] = `SEG_DASH;
                    else
                        digits[3-i] = letter_seg(guess[i]);
                end
            end
            mastermind_pkg::EVAL_GUESS: begin
                for (int i = 0; i < `CODE_LEN; i++)
                    digits[3-i] = letter_seg(guess[i]);
            end
            mastermind_pkg::SHOW_SECRET: begin
                for (int i = 0; i < `CODE_LEN; i++)
                    digits[3-i] = letter_seg(secret[i]);
            end
            default: begin
            end
        endcase
    end

    assign {ssd3, ssd2, ssd1, ssd0} = digits;

    // Flash pattern flips every quarter of the result screen
    assign quarter     = timer / `TIMER_W'(`SHOW_TICKS / 4);
    assign win_reached = (score_a == mastermind_pkg::score_t'(`WIN_SCORE)) ||
                         (score_b == mastermind_pkg::score_t'(`WIN_SCORE));

    always_comb begin
        if (state == mastermind_pkg::EVAL_GUESS)
            led = led_pairs;
        else if (state == mastermind_pkg::SHOW_RESULT && win_reached)
            led = quarter[0] ? 8'b01010101 : 8'b10101010;
        else
            led = '0;
    end

endmodule

/* source/guess_eval.sv */
`include "mastermind_macros.svh"

module guess_eval (
    input  mastermind_pkg::letter_t [`CODE_LEN-1:0] secret,
    input  mastermind_pkg::letter_t [`CODE_LEN-1:0] guess,
    output logic [2*`CODE_LEN-1:0]                  led_pairs,
    output logic                                    all_correct
);

    logic [`CODE_LEN-1:0] exact;
    logic [`CODE_LEN-1:0] present;

    always_comb begin
        for (int i = 0; i < `CODE_LEN; i++) begin
            exact[i]   = (guess[i] == secret[i]);
            present[i] = 1'b0;
            for (int j = 0; j < `CODE_LEN; j++) begin
                if (j != i && guess[i] == secret[j])
                    present[i] = 1'b1;
            end
            // First letter on the top pair
            if (exact[i])
                led_pairs[2*(`CODE_LEN-1-i) +: 2] = 2'b11;
            else if (present[i])
                led_pairs[2*(`CODE_LEN-1-i) +: 2] = 2'b01;
            else
                led_pairs[2*(`CODE_LEN-1-i) +: 2] = 2'b00;
        end
    end

    assign all_correct = &exact;

endmodule

/* source/mastermind_top.sv */
`include "mastermind_macros.svh"

module mastermind_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    enter_a,
    input  logic                    enter_b,
    input  mastermind_pkg::letter_t letter_in,
    output logic [7:0]              led,
    output logic [6:0]              ssd3,
    output logic [6:0]              ssd2,
    output logic [6:0]              ssd1,
    output logic [6:0]              ssd0
);

    mastermind_pkg::game_state_t                  state;
    mastermind_pkg::lives_t                       lives;
    mastermind_pkg::score_t                       score_a;
    mastermind_pkg::score_t                       score_b;
    mastermind_pkg::letter_t [`CODE_LEN-1:0]      secret;
    mastermind_pkg::letter_t [`CODE_LEN-1:0]      guess;
    logic                                         store_secret;
    logic                                         store_guess;
    logic                                         clear_guess;
    logic                                         cm_is_a;
    logic [`TIMER_W-1:0]                          timer;
    logic [`CNT_W-1:0]                            entry_count;
    logic                                         code_full;
    logic                                         all_correct;
    logic [2*`CODE_LEN-1:0]                       led_pairs;

    game_fsm u_fsm (
        .clk          (clk),
        .rst          (rst),
        .enter_a      (enter_a),
        .enter_b      (enter_b),
        .letter_in    (letter_in),
        .code_full    (code_full),
        .all_correct  (all_correct),
        .state        (state),
        .store_secret (store_secret),
        .store_guess  (store_guess),
        .clear_guess  (clear_guess),
        .cm_is_a      (cm_is_a),
        .lives        (lives),
        .score_a      (score_a),
        .score_b      (score_b),
        .timer        (timer)
    );

    code_regs u_code (
        .clk          (clk),
        .rst          (rst),
        .letter_in    (letter_in),
        .store_secret (store_secret),
        .store_guess  (store_guess),
        .clear_guess  (clear_guess),
        .state        (state),
        .secret       (secret),
        .guess        (guess),
        .entry_count  (entry_count),
        .code_full    (code_full)
    );

    guess_eval u_eval (
        .secret      (secret),
        .guess       (guess),
        .led_pairs   (led_pairs),
        .all_correct (all_correct)
    );

    display_decode u_disp (
        .state       (state),
        .secret      (secret),
        .guess       (guess),
        .entry_count (entry_count),
        .cm_is_a     (cm_is_a),
        .lives       (lives),
        .score_a     (score_a),
        .score_b     (score_b),
        .led_pairs   (led_pairs),
        .timer       (timer),
        .led         (led),
        .ssd3        (ssd3),
        .ssd2        (ssd2),
        .ssd1        (ssd1),
        .ssd0        (ssd0)
    );

endmodule

/* tests/mastermind_assertions.sv */
module mastermind_assertions (
    input logic                        clk,
    input logic                        rst,
    input mastermind_pkg::game_state_t state,
    input logic                        store_secret,
    input logic                        store_guess,
    input mastermind_pkg::lives_t      lives,
    input logic [7:0]                  led
);

    int fails = 0;

    // Letters only land while a player is entering a code
    store_in_entry: assert property (@(posedge clk) disable iff (!rst)
        (store_secret || store_guess) |->
            (state == mastermind_pkg::CM_ENTRY || state == mastermind_pkg::CB_ENTRY))
    else begin
        $error("store pulse outside the entry states");
        fails++;
    end

    lives_nonzero: assert property (@(posedge clk) disable iff (!rst)
        (lives == '0) |-> (state == mastermind_pkg::SHOW_RESULT))
    else begin
        $error("lives reached zero outside the result screen");
        fails++;
    end

    // LED bar is dark on the start screen
    start_led_dark: assert property (@(posedge clk) disable iff (!rst)
        (state == mastermind_pkg::START) |-> (led == 8'h00))
    else begin
        $error("led not zero on the start screen");
        fails++;
    end

endmodule

bind mastermind_top mastermind_assertions u_asserts (
    .clk          (clk),
    .rst          (rst),
    .state        (state),
    .store_secret (store_secret),
    .store_guess  (store_guess),
    .lives        (lives),
    .led          (led)
);

/* tests/mastermind_tb.sv */
`include "mastermind_macros.svh"

module mastermind_tb;

    typedef mastermind_pkg::letter_t [`CODE_LEN-1:0] code_t;

    // About 30 screens plus letter gaps, with a wide margin
    localparam int TIMEOUT_CYCLES = 400 * `SHOW_TICKS;

    logic                    clk;
    logic                    rst;
    logic                    enter_a;
    logic                    enter_b;
    mastermind_pkg::letter_t letter_in;
    logic [7:0]              led;
    logic [6:0]              ssd3;
    logic [6:0]              ssd2;
    logic [6:0]              ssd1;
    logic [6:0]              ssd0;
    logic [27:0]             shown;
    int                      errors = 0;
    int                      checks = 0;
    int                      tests = 0;
    int                      test_start = 0;
    int                      cycles = 0;
    code_t                   secret_one;
    code_t                   secret_two;

    assign shown = {ssd3, ssd2, ssd1, ssd0};

    mastermind_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .enter_a   (enter_a),
        .enter_b   (enter_b),
        .letter_in (letter_in),
        .led       (led),
        .ssd3      (ssd3),
        .ssd2      (ssd2),
        .ssd1      (ssd1),
        .ssd0      (ssd0)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles without reaching the end", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic tick();
        @(posedge clk);
        #5;
    endtask

    task automatic check_led(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_seg(input string name, input logic [6:0] got, input logic [6:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_letter(input string name, input mastermind_pkg::letter_t got,
                                input mastermind_pkg::letter_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    function automatic logic [6:0] slot_seg(input int i);
        return shown[(`CODE_LEN-1-i)*7 +: 7];
    endfunction

    // Reads a letter back from its segment pattern
    function automatic mastermind_pkg::letter_t seg_to_letter(input logic [6:0] seg);
        case (seg)
            `SEG_A:  return 3'd1;
            `SEG_C:  return 3'd2;
            `SEG_E:  return 3'd3;
            `SEG_F:  return 3'd4;
            `SEG_H:  return 3'd5;
            `SEG_L:  return 3'd6;
            `SEG_U:  return 3'd7;
            default: return 3'd0;
        endcase
    endfunction

    // Four distinct nonzero letters
    function automatic code_t random_code();
        code_t                   c;
        logic [7:0]              used;
        mastermind_pkg::letter_t l;
        used = '0;
        for (int i = 0; i < `CODE_LEN; i++) begin
            l = 3'($urandom_range(7, 1));
            while (used[l])
                l = 3'($urandom_range(7, 1));
            used[l] = 1'b1;
            c[i] = l;
        end
        return c;
    endfunction

    // One exact, one present elsewhere, two absent
    function automatic code_t near_miss(input code_t s);
        code_t                   g;
        mastermind_pkg::letter_t absent;
        mastermind_pkg::letter_t cand;
        absent = 3'd1;
        for (cand = 3'd7; cand != 3'd0; cand--) begin
            if (s[0] != cand && s[1] != cand && s[2] != cand && s[3] != cand)
                absent = cand;
        end
        g[0] = s[0];
        g[1] = s[2];
        g[2] = absent;
        g[3] = absent;
        return g;
    endfunction

    task automatic wait_screen(input string name, input logic [27:0] pattern);
        int n;
        n = 0;
        while (shown !== pattern && n < 4 * `SHOW_TICKS) begin
            tick();
            n++;
        end
        if (shown !== pattern) begin
            errors++;
            $display("The %s screen did not appear within %0d cycles", name, n);
        end
    endtask

    task automatic press(input logic player_a);
        enter_a = player_a;
        enter_b = !player_a;
        tick();
        enter_a = 1'b0;
        enter_b = 1'b0;
    endtask

    task automatic enter_code(input logic player_a, input code_t code, input logic masked);
        for (int i = 0; i < `CODE_LEN; i++) begin
            letter_in = code[i];
            press(player_a);
            letter_in = '0;
            if (masked)
                check_seg($sformatf("ssd slot %0d", i), slot_seg(i), `SEG_DASH);
            else
                check_letter($sformatf("guess slot %0d", i), seg_to_letter(slot_seg(i)),
                             code[i]);
            repeat (`LETTER_GAP) tick();
        end
        tick();
    endtask

    task automatic check_secret_shown(input code_t code);
        for (int i = 0; i < `CODE_LEN; i++)
            check_letter($sformatf("secret slot %0d", i), seg_to_letter(slot_seg(i)), code[i]);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("%s: %s", name, (errors == test_start) ? "pass" : "fail");
        test_start = errors;
    endtask

    task automatic test_reset();
        check_seg("ssd3", ssd3, `SEG_OFF);
        check_seg("ssd2", ssd2, `SEG_A);
        check_seg("ssd1", ssd1, `SEG_DASH);
        check_seg("ssd0", ssd0, `SEG_B);
        check_led("led", led, 8'h00);
        end_test("reset");
    endtask

    task automatic test_player_a_start();
        press(1'b1);
        wait_screen("score 0-0", {`SEG_OFF, `SEG_0, `SEG_DASH, `SEG_0});
        wait_screen("codemaker A", {`SEG_OFF, `SEG_P, `SEG_DASH, `SEG_A});
        wait_screen("secret entry", {4{`SEG_OFF}});
        enter_code(1'b1, secret_one, 1'b1);
        end_test("player A start");
    endtask

    task automatic test_wrong_guess();
        wait_screen("codebreaker B", {`SEG_OFF, `SEG_P, `SEG_DASH, `SEG_B});
        wait_screen("lives 3", {`SEG_OFF, `SEG_L, `SEG_DASH, `SEG_3});
        wait_screen("guess entry", {4{`SEG_OFF}});
        enter_code(1'b0, near_miss(secret_one), 1'b0);
        check_led("led", led, {2'b11, 2'b01, 2'b00, 2'b00});
        press(1'b0);
        check_seg("ssd2", ssd2, `SEG_L);
        check_seg("ssd0", ssd0, `SEG_2);
        end_test("wrong guess");
    endtask

    task automatic test_correct_guess();
        wait_screen("guess entry", {4{`SEG_OFF}});
        enter_code(1'b0, secret_one, 1'b0);
        check_led("led", led, 8'hff);
        press(1'b0);
        check_secret_shown(secret_one);
        wait_screen("score 0-1", {`SEG_OFF, `SEG_0, `SEG_DASH, `SEG_1});
        check_led("led", led, 8'h00);
        end_test("correct guess");
    endtask

    task automatic test_three_wrong();
        wait_screen("codemaker B", {`SEG_OFF, `SEG_P, `SEG_DASH, `SEG_B});
        wait_screen("secret entry", {4{`SEG_OFF}});
        enter_code(1'b0, secret_two, 1'b1);
        wait_screen("codebreaker A", {`SEG_OFF, `SEG_P, `SEG_DASH, `SEG_A});
        for (int k = 0; k < `START_LIVES; k++) begin
            wait_screen("lives", {`SEG_OFF, `SEG_L, `SEG_DASH,
                                  (k == 0) ? `SEG_3 : (k == 1) ? `SEG_2 : `SEG_1});
            wait_screen("guess entry", {4{`SEG_OFF}});
            enter_code(1'b1, near_miss(secret_two), 1'b0);
            check_led("led", led, {2'b11, 2'b01, 2'b00, 2'b00});
            press(1'b1);
        end
        check_secret_shown(secret_two);
        end_test("three wrong guesses");
    endtask

    task automatic test_win();
        wait_screen("score 0-2", {`SEG_OFF, `SEG_0, `SEG_DASH, `SEG_2});
        check_led("led", led, 8'b10101010);
        repeat (`SHOW_TICKS / 4) tick();
        check_led("led", led, 8'b01010101);
        wait_screen("start", {`SEG_OFF, `SEG_A, `SEG_DASH, `SEG_B});
        check_led("led", led, 8'h00);
        end_test("win");
    endtask

    initial begin
        void'($urandom(32'h1e61_1674));
        rst       = 1'b0;
        enter_a   = 1'b0;
        enter_b   = 1'b0;
        letter_in = '0;
        secret_one = random_code();
        secret_two = random_code();
        repeat (5) @(posedge clk);
        #5;
        rst = 1'b1;
        tick();
        test_reset();
        test_player_a_start();
        test_wrong_guess();
        test_correct_guess();
        test_three_wrong();
        test_win();
        errors = errors + u_dut.u_asserts.fails;
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, u_dut.u_asserts.fails);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
